//--- build.f
hw/debugClassPkg.sv
hw/setupDecoder.sv
hw/requestControl.sv
hw/wordCollector.sv
hw/deviceRegisters.sv
hw/debugClassControl.sv
verification/debugClassAssertions.sv
verification/debugClassTb.sv

//--- hw/debugClassControl.sv
`timescale 1ns/1ps

module debugClassControl (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      enable,
	input  debugClassPkg::setupPacketT setupPacket,
	input  logic [31:0]               paramWord32,
	input  logic [63:0]               paramWord64,
	input  logic [31:0]               opModeIn,
	output logic                      busy,
	output debugClassPkg::scopeT       scope,
	output debugClassPkg::targetIdT    target,
	output logic [63:0]               address,
	output logic [63:0]               singleData,
	output logic [63:0]               bufferCommand,
	output logic [31:0]               opModeOut,
	output logic                      endpointReset,
	output logic [31:0]               readData32,
	output logic [63:0]               readData64
);
	import debugClassPkg::*;

	decodedReqT  request;
	logic        capture;
	logic        doExecute;
	logic        collectStrobe;
	logic [1:0]  collectIndex;
	logic        singleDone;
	logic [63:0] collectedAddress;
	logic [63:0] collectedData;

	setupDecoder decoderInst (
		.clk(clk), .rst(rst), .enable(enable),
		.capture(capture),
		.setupPacket(setupPacket),
		.request(request)
	);

	requestControl controlInst (
		.clk(clk), .rst(rst), .enable(enable),
		.request(request),
		.capture(capture),
		.doExecute(doExecute),
		.collectStrobe(collectStrobe),
		.collectIndex(collectIndex),
		.busy(busy)
	);

	wordCollector collectorInst (
		.clk(clk), .rst(rst), .enable(enable),
		.collectStrobe(collectStrobe),
		.collectIndex(collectIndex),
		.paramWord32(paramWord32),
		.singleDone(singleDone),
		.collectedAddress(collectedAddress),
		.collectedData(collectedData)
	);

	deviceRegisters registersInst (
		.clk(clk), .rst(rst), .enable(enable),
		.request(request),
		.doExecute(doExecute),
		.singleDone(singleDone),
		.collectedAddress(collectedAddress),
		.collectedData(collectedData),
		.paramWord32(paramWord32),
		.paramWord64(paramWord64),
		.opModeIn(opModeIn),
		.scope(scope),
		.target(target),
		.address(address),
		.singleData(singleData),
		.bufferCommand(bufferCommand),
		.opModeOut(opModeOut),
		.endpointReset(endpointReset),
		.readData32(readData32),
		.readData64(readData64)
	);

endmodule

//--- hw/debugClassPkg.sv
package debugClassPkg;

	// setup packet as it arrives, top byte first
	typedef struct packed {
		logic [7:0]  requestType;
		logic [7:0]  requestCode;
		logic [15:0] wValue;
		logic [15:0] wIndex;
		logic [15:0] wLength;
	} setupPacketT;

	typedef struct packed {
		logic isGlobal;
		logic isLocal;
		logic isSpecific;
	} scopeT;

	// split of wIndex
	typedef struct packed {
		logic [7:0] debugUnitId;
		logic [7:0] interfaceId;
	} targetIdT;

	typedef enum logic [3:0] {
		reqNone,
		reqSetSingle,
		reqSetAddress,
		reqSetOpMode,
		reqSetBuffer,
		reqSetReset,
		reqGetAddress,
		reqGetOpMode,
		reqGetInfo
	} requestKindT;

	typedef struct packed {
		requestKindT kind;
		scopeT       scope;
		targetIdT    target;
		logic        accept; // code and scope both legal
	} decodedReqT;

	typedef enum logic [1:0] {sIdle, sDecode, sExecute, sCollect} ctrlStateT;

	localparam logic [7:0] SET_REQUEST_TYPE = 8'h21; // host to interface, class
	localparam logic [7:0] GET_REQUEST_TYPE = 8'hA1;

	localparam logic [7:0] CODE_SET_SINGLE  = 8'h02;
	localparam logic [7:0] CODE_SET_ADDRESS = 8'h03;
	localparam logic [7:0] CODE_SET_OPMODE  = 8'h05;
	localparam logic [7:0] CODE_SET_BUFFER  = 8'h09;
	localparam logic [7:0] CODE_SET_RESET   = 8'h0A;
	localparam logic [7:0] CODE_GET_ADDRESS = 8'h83;
	localparam logic [7:0] CODE_GET_OPMODE  = 8'h85;
	localparam logic [7:0] CODE_GET_INFO    = 8'h87;

	localparam logic [7:0] WVALUE_GLOBAL = 8'h00;
	localparam logic [7:0] WVALUE_LOCAL  = 8'h02;

	// single, set addr, get addr, set opmode, get opmode, set buffer, set reset
	localparam logic [31:0] CAPABILITY_WORD = 32'h0000_2999;

	localparam int SINGLE_WORDS = 4;

endpackage

//--- hw/deviceRegisters.sv
`timescale 1ns/1ps

module deviceRegisters (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     enable,
	input  debugClassPkg::decodedReqT request,
	input  logic                     doExecute,
	input  logic                     singleDone,
	input  logic [63:0]              collectedAddress,
	input  logic [63:0]              collectedData,
	input  logic [31:0]              paramWord32,
	input  logic [63:0]              paramWord64,
	input  logic [31:0]              opModeIn,
	output debugClassPkg::scopeT     scope,
	output debugClassPkg::targetIdT  target,
	output logic [63:0]              address,
	output logic [63:0]              singleData,
	output logic [63:0]              bufferCommand,
	output logic [31:0]              opModeOut,
	output logic                     endpointReset,
	output logic [31:0]              readData32,
	output logic [63:0]              readData64
);
	import debugClassPkg::*;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			scope         <= '0;
			endpointReset <= 1'b0;
		end
		else if (enable)
		begin
			endpointReset <= doExecute && (request.kind == reqSetReset); // one cycle
			if (doExecute)
				scope <= request.scope;
		end
	end

	always_ff @(posedge clk)
	begin
		if (enable && doExecute)
		begin
			target <= request.target; // held until the next accepted request
			case (request.kind)
				reqSetAddress: address       <= paramWord64;
				reqSetOpMode:  opModeOut     <= paramWord32;
				reqSetBuffer:  bufferCommand <= paramWord64;
				reqGetAddress: readData64    <= address;
				reqGetOpMode:  readData32    <= opModeIn;
				reqGetInfo:    readData32    <= CAPABILITY_WORD;
				default:       ;
			endcase
		end

		// end of a single write, both words land together
		if (enable && singleDone)
		begin
			address    <= collectedAddress;
			singleData <= collectedData;
		end
	end

endmodule

//--- hw/requestControl.sv
`timescale 1ns/1ps

module requestControl (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     enable,
	input  debugClassPkg::decodedReqT request,
	output logic                     capture,
	output logic                     doExecute,
	output logic                     collectStrobe,
	output logic [1:0]               collectIndex,
	output logic                     busy
);
	import debugClassPkg::*;

	ctrlStateT  state;
	ctrlStateT  nextState;
	logic [1:0] wordCount;
	logic       lastWord;

	assign lastWord = wordCount == 2'(SINGLE_WORDS - 1);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state     <= sIdle;
			wordCount <= '0;
		end
		else if (enable)
		begin
			state <= nextState;
			if (state == sCollect)
				wordCount <= wordCount + 2'd1;
			else
				wordCount <= '0;
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			sIdle:
			begin
				nextState = sDecode; // packet captured on this edge
			end
			sDecode:
			begin
				if (request.accept)
					nextState = sExecute;
				else
					nextState = sIdle;
			end
			sExecute:
			begin
				// only the single write needs parameter words afterwards
				if (request.kind == reqSetSingle)
					nextState = sCollect;
				else
					nextState = sIdle;
			end
			sCollect:
			begin
				if (lastWord)
					nextState = sIdle;
			end
			default:
			begin
				nextState = sIdle;
			end
		endcase
	end

	assign capture       = state == sIdle;
	assign doExecute     = state == sExecute;
	assign collectStrobe = state == sCollect;
	assign collectIndex  = wordCount;

	// decode cycle stays quiet so rejects never show busy
	assign busy = doExecute || collectStrobe;

endmodule

//--- hw/setupDecoder.sv
`timescale 1ns/1ps

module setupDecoder (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      enable,
	input  logic                      capture,
	input  debugClassPkg::setupPacketT setupPacket,
	output debugClassPkg::decodedReqT  request
);
	import debugClassPkg::*;

	setupPacketT packet;
	requestKindT kind;
	scopeT       scope;
	targetIdT    target;
	logic        typeOk;

	always_ff @(posedge clk)
	begin
		if (rst)
			packet <= '0;
		else if (enable && capture)
			packet <= setupPacket;
	end

	assign target.debugUnitId = packet.wIndex[15:8];
	assign target.interfaceId = packet.wIndex[7:0];

	// code bit 7 gives the transfer direction
	assign typeOk = packet.requestCode[7] ? (packet.requestType == GET_REQUEST_TYPE)
		: (packet.requestType == SET_REQUEST_TYPE);

	always_comb
	begin
		case (packet.requestCode)
			CODE_SET_SINGLE:  kind = reqSetSingle;
			CODE_SET_ADDRESS: kind = reqSetAddress;
			CODE_SET_OPMODE:  kind = reqSetOpMode;
			CODE_SET_BUFFER:  kind = reqSetBuffer;
			CODE_SET_RESET:   kind = reqSetReset;
			CODE_GET_ADDRESS: kind = reqGetAddress;
			CODE_GET_OPMODE:  kind = reqGetOpMode;
			CODE_GET_INFO:    kind = reqGetInfo;
			default:          kind = reqNone;
		endcase
		if (!typeOk)
			kind = reqNone; // wrong direction for this code
	end

	always_comb
	begin
		scope = '0;
		if (target.debugUnitId == 8'h00)
		begin
			scope.isGlobal = packet.wValue[7:0] == WVALUE_GLOBAL;
			scope.isLocal  = packet.wValue[7:0] == WVALUE_LOCAL;
		end
		else
			scope.isSpecific = packet.wValue[7:0] == 8'h00; // unit only takes class 0
	end

	assign request.kind   = kind;
	assign request.scope  = scope;
	assign request.target = target;
	assign request.accept = (kind != reqNone) && (|scope);

endmodule

//--- hw/wordCollector.sv
`timescale 1ns/1ps

module wordCollector (
	input  logic        clk,
	input  logic        rst,
	input  logic        enable,
	input  logic        collectStrobe,
	input  logic [1:0]  collectIndex,
	input  logic [31:0] paramWord32,
	output logic        singleDone,
	output logic [63:0] collectedAddress,
	output logic [63:0] collectedData
);

	logic [31:0] addressHigh;
	logic [31:0] addressLow;
	logic [31:0] dataHigh;

	// word order is address high, address low, data high, data low
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			addressHigh <= '0;
			addressLow  <= '0;
			dataHigh    <= '0;
		end
		else if (enable && collectStrobe)
		begin
			case (collectIndex)
				2'd0:    addressHigh <= paramWord32;
				2'd1:    addressLow  <= paramWord32;
				2'd2:    dataHigh    <= paramWord32;
				default: ;
			endcase
		end
	end

	assign singleDone = collectStrobe && (collectIndex == 2'd3);

	assign collectedAddress = {addressHigh, addressLow};

	// data low goes straight from the bus into singleData on the last strobe
	assign collectedData = {dataHigh, paramWord32};

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
	--top-module debugClassTb -o debugClassSim \
	&& ./obj_dir/debugClassSim | tee /dev/stderr | grep -q "^TEST PASS$" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- verification/debugClassAssertions.sv
`timescale 1ns/1ps

module debugClassAssertions (
	input logic                 clk,
	input logic                 rst,
	input logic                 busy,
	input logic                 endpointReset,
	input debugClassPkg::scopeT scope
);

	// controller idle and reset pulse off once reset has been seen
	quietAfterReset: assert property (@(posedge clk) rst |=> (!busy && !endpointReset))
		else $error("busy or endpointReset active right after reset");

	pulseOneCycle: assert property (@(posedge clk) disable iff (rst)
		endpointReset |=> !endpointReset)
		else $error("endpointReset high for two cycles in a row");

	scopeOneHot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({scope.isGlobal, scope.isLocal, scope.isSpecific}))
		else $error("more than one scope flag set");

endmodule

bind debugClassControl debugClassAssertions assertInst (
	.clk(clk),
	.rst(rst),
	.busy(busy),
	.endpointReset(endpointReset),
	.scope(scope)
);

//--- verification/debugClassTb.sv
`timescale 1ns/1ps

module debugClassTb;
	import debugClassPkg::*;

	localparam int BUSY_TIMEOUT = 20;
	localparam logic [7:0] CODE_RESERVED = 8'h7F; // not a kept request code
	// bits 0, 3, 4, 7, 8, 11 and 13 for the kept requests
	localparam logic [31:0] INFO_EXPECTED = (32'd1 << 0) | (32'd1 << 3) | (32'd1 << 4)
		| (32'd1 << 7) | (32'd1 << 8) | (32'd1 << 11) | (32'd1 << 13);

	logic        clk;
	logic        rst;
	logic        enable;
	setupPacketT setupPacket;
	logic [31:0] paramWord32;
	logic [63:0] paramWord64;
	logic [31:0] opModeIn;
	logic        busy;
	scopeT       scope;
	targetIdT    target;
	logic [63:0] address;
	logic [63:0] singleData;
	logic [63:0] bufferCommand;
	logic [31:0] opModeOut;
	logic        endpointReset;
	logic [31:0] readData32;
	logic [63:0] readData64;

	int          errors = 0;
	int          checks = 0;
	int          resetHighCycles = 0;
	logic [31:0] rngState = 32'hcf3b;

	debugClassControl uut (
		.clk(clk), .rst(rst), .enable(enable),
		.setupPacket(setupPacket),
		.paramWord32(paramWord32),
		.paramWord64(paramWord64),
		.opModeIn(opModeIn),
		.busy(busy),
		.scope(scope),
		.target(target),
		.address(address),
		.singleData(singleData),
		.bufferCommand(bufferCommand),
		.opModeOut(opModeOut),
		.endpointReset(endpointReset),
		.readData32(readData32),
		.readData64(readData64)
	);

	always #20 clk = ~clk;

	// counts cycles with the endpoint reset high at the falling edge
	always @(negedge clk)
	begin
		if (endpointReset === 1'b1)
			resetHighCycles <= resetHighCycles + 1;
	end

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic setupPacketT makePacket(input logic [7:0] reqType,
		input logic [7:0] code, input logic [15:0] value, input logic [15:0] index);
		setupPacketT p;
		p.requestType = reqType;
		p.requestCode = code;
		p.wValue      = value;
		p.wIndex      = index;
		p.wLength     = 16'd0;
		return p;
	endfunction

	function automatic setupPacketT idlePacket();
		return makePacket(SET_REQUEST_TYPE, CODE_RESERVED, 16'h0000, 16'h0000);
	endfunction

	function automatic scopeT makeScope(input logic g, input logic l, input logic s);
		scopeT sc;
		sc.isGlobal   = g;
		sc.isLocal    = l;
		sc.isSpecific = s;
		return sc;
	endfunction

	function automatic targetIdT splitIndex(input logic [15:0] index);
		targetIdT t;
		t.debugUnitId = index[15:8]; // high byte names the unit
		t.interfaceId = index[7:0];
		return t;
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic checkFlag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkWord32(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkWord64(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkScope(input string what, input scopeT got, input scopeT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkTarget(input string what, input targetIdT got, input targetIdT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic waitBusy(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (busy !== level && cycles < BUSY_TIMEOUT)
		begin
			nextCycle();
			cycles++;
		end
		if (busy !== level)
		begin
			$display("timeout: busy never went to %b during %s", level, what);
			$display("TEST FAIL");
			$finish;
		end
	endtask

	// one request and then the reserved code so the packet is not run twice
	task automatic runRequest(input setupPacketT packet, input string what);
		setupPacket = packet;
		waitBusy(1'b1, what);
		waitBusy(1'b0, what);
		setupPacket = idlePacket();
	endtask

	task automatic runSingle(input setupPacketT packet, input logic [31:0] words [4],
		input logic stall);
		setupPacket = packet;
		waitBusy(1'b1, "set single start");
		nextCycle(); // words are sampled on the four edges after execute
		for (int i = 0; i < SINGLE_WORDS; i++)
		begin
			paramWord32 = words[i];
			if (stall && i == 2)
			begin
				enable = 1'b0;
				repeat (3) nextCycle();
				checkFlag("busy during stall", busy, 1'b1);
				enable = 1'b1;
			end
			nextCycle();
		end
		waitBusy(1'b0, "set single end");
		setupPacket = idlePacket();
	endtask

	task automatic expectReject(input setupPacketT packet, input string what);
		logic sawBusy;
		sawBusy = 1'b0;
		setupPacket = packet;
		repeat (8) // several capture and decode rounds
		begin
			nextCycle();
			if (busy !== 1'b0)
				sawBusy = 1'b1;
		end
		checkFlag({what, " raised busy"}, sawBusy, 1'b0);
		setupPacket = idlePacket();
		nextCycle();
	endtask

	task automatic testAddressGlobal();
		logic [63:0] payload;
		payload = {nextRandom(), nextRandom()};
		paramWord64 = payload;
		runRequest(makePacket(SET_REQUEST_TYPE, CODE_SET_ADDRESS, {8'h00, WVALUE_GLOBAL},
			16'h0001), "set address");
		checkWord64("address after set", address, payload);
		runRequest(makePacket(GET_REQUEST_TYPE, CODE_GET_ADDRESS, {8'h00, WVALUE_GLOBAL},
			16'h0001), "get address");
		checkWord64("get address read-back", readData64, payload);
		checkScope("global scope", scope, makeScope(1'b1, 1'b0, 1'b0));
	endtask

	task automatic testSingleLocal();
		logic [31:0] words [4];
		foreach (words[i])
			words[i] = nextRandom();
		runSingle(makePacket(SET_REQUEST_TYPE, CODE_SET_SINGLE, {8'h00, WVALUE_LOCAL},
			16'h0003), words, 1'b0);
		checkWord64("single address", address, {words[0], words[1]});
		checkWord64("single data", singleData, {words[2], words[3]});
		checkScope("local scope", scope, makeScope(1'b0, 1'b1, 1'b0));
	endtask

	task automatic testOpModeSpecific();
		logic [31:0] mode;
		logic [15:0] index;
		mode = nextRandom();
		index = 16'h4507; // unit 45 and interface 7
		paramWord32 = mode;
		runRequest(makePacket(SET_REQUEST_TYPE, CODE_SET_OPMODE, 16'h0000, index),
			"set opmode");
		checkWord32("opModeOut", opModeOut, mode);
		checkTarget("specific target", target, splitIndex(index));
		checkScope("specific scope", scope, makeScope(1'b0, 1'b0, 1'b1));
		opModeIn = nextRandom();
		runRequest(makePacket(GET_REQUEST_TYPE, CODE_GET_OPMODE, 16'h0000, index),
			"get opmode");
		checkWord32("get opmode read-back", readData32, opModeIn);
	endtask

	task automatic testBufferResetInfo();
		logic [63:0] command;
		int          highBefore;
		command = {nextRandom(), nextRandom()};
		paramWord64 = command;
		runRequest(makePacket(SET_REQUEST_TYPE, CODE_SET_BUFFER, 16'h0000, 16'h0002),
			"set buffer");
		checkWord64("bufferCommand", bufferCommand, command);
		highBefore = resetHighCycles;
		runRequest(makePacket(SET_REQUEST_TYPE, CODE_SET_RESET, 16'h0000, 16'h0002),
			"set reset");
		repeat (3) nextCycle(); // let the pulse pass
		checkWord32("endpointReset high cycles", 32'(resetHighCycles - highBefore), 32'd1);
		checkFlag("endpointReset after pulse", endpointReset, 1'b0);
		runRequest(makePacket(GET_REQUEST_TYPE, CODE_GET_INFO, 16'h0000, 16'h0002),
			"get info");
		checkWord32("capability word", readData32, INFO_EXPECTED);
	endtask

	task automatic testRejects();
		logic [63:0] addressBefore;
		logic [31:0] modeBefore;
		scopeT       scopeBefore;
		targetIdT    targetBefore;
		addressBefore = address;
		modeBefore    = opModeOut;
		scopeBefore   = scope;
		targetBefore  = target;
		paramWord64 = {nextRandom(), nextRandom()};
		paramWord32 = nextRandom();
		// set code carried with the get request type
		expectReject(makePacket(GET_REQUEST_TYPE, CODE_SET_ADDRESS, 16'h0000, 16'h0000),
			"wrong request type");
		expectReject(makePacket(SET_REQUEST_TYPE, CODE_SET_OPMODE, {8'h00, WVALUE_LOCAL},
			16'h3000), "unit with local class");
		checkWord64("address after rejects", address, addressBefore);
		checkWord32("opModeOut after rejects", opModeOut, modeBefore);
		checkScope("scope after rejects", scope, scopeBefore);
		checkTarget("target after rejects", target, targetBefore);
	endtask

	task automatic testStalledSingle();
		logic [31:0] words [4];
		foreach (words[i])
			words[i] = nextRandom();
		runSingle(makePacket(SET_REQUEST_TYPE, CODE_SET_SINGLE, {8'h00, WVALUE_GLOBAL},
			16'h0000), words, 1'b1);
		checkWord64("stalled single address", address, {words[0], words[1]});
		checkWord64("stalled single data", singleData, {words[2], words[3]});
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		enable = 1'b1;
		setupPacket = idlePacket();
		paramWord32 = '0;
		paramWord64 = '0;
		opModeIn = '0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		nextCycle();

		testAddressGlobal();
		testSingleLocal();
		testOpModeSpecific();
		testBufferResetInfo();
		testRejects();
		testStalledSingle();

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
